/* design/nes_mem_pkg.sv */
// NES memory controller types
package nes_mem_pkg;

	////////////////////////////////
	// Data and address widths
	////////////////////////////////
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] byte_t;
	typedef logic [13:0] vram_addr_t;

	// Nametable arrangement
	typedef enum logic {
		MIRROR_HORIZONTAL,
		MIRROR_VERTICAL
	} mirror_e;

	// Where a CPU address lands
	typedef enum logic [1:0] {
		REGION_WRAM,
		REGION_REG,
		REGION_PAD,
		REGION_NONE
	} region_e;

	// Owner of the previous VRAM cycle
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_PPU,
		ARB_CPU
	} arb_state_e;

	////////////////////////////////
	// Register offsets in 0x2000
	////////////////////////////////
	localparam logic [2:0] REG_CTRL = 3'd0;
	localparam logic [2:0] REG_MASK = 3'd1;
	localparam logic [2:0] REG_STATUS = 3'd2;
	localparam logic [2:0] REG_OAM_ADDR = 3'd3;
	localparam logic [2:0] REG_OAM_DATA = 3'd4;
	localparam logic [2:0] REG_SCROLL = 3'd5;
	localparam logic [2:0] REG_ADDR = 3'd6;
	localparam logic [2:0] REG_DATA = 3'd7;

endpackage

/* design/cpu_addr_decode.sv */
// CPU address decoder
module cpu_addr_decode #(
	parameter int WRAM_BYTES = 2048
) (
	input nes_mem_pkg::cpu_addr_t addr,
	output nes_mem_pkg::region_e region,
	output logic [10:0] wram_addr,
	output logic [2:0] reg_sel,
	output logic pad_sel
);

	// Work RAM repeats every WRAM_BYTES up to 0x1FFF
	assign wram_addr = 11'(addr % nes_mem_pkg::cpu_addr_t'(WRAM_BYTES));

	// Eight registers repeat every 8 bytes
	assign reg_sel = addr[2:0];

	// 0x4016 is pad 1, 0x4017 is pad 2
	assign pad_sel = addr[0];

	always_comb begin
		if (addr[15:13] == 3'b000) begin
			region = nes_mem_pkg::REGION_WRAM;
		end else if (addr[15:13] == 3'b001) begin
			region = nes_mem_pkg::REGION_REG;
		end else if (addr[15:1] == 15'h200B) begin
			region = nes_mem_pkg::REGION_PAD;
		end else begin
			// Reads zero, writes dropped
			region = nes_mem_pkg::REGION_NONE;
		end
	end

endmodule

/* design/vram_addr_map.sv */
// VRAM address mirroring
module vram_addr_map (
	input nes_mem_pkg::vram_addr_t addr_in,
	input nes_mem_pkg::mirror_e mirror_mode,
	output nes_mem_pkg::vram_addr_t addr_out
);

	logic [1:0] nt_in;
	logic [1:0] nt_out;
	logic pal_hi;

	assign nt_in = addr_in[11:10];

	// Vertical keeps the column, horizontal keeps the row
	always_comb begin
		if (mirror_mode == nes_mem_pkg::MIRROR_VERTICAL) begin
			nt_out = {1'b0, nt_in[0]};
		end else begin
			nt_out = {nt_in[1], 1'b0};
		end
	end

	// Sprite backdrop entries share the background ones
	assign pal_hi = (addr_in[1:0] == 2'b00) ? 1'b0 : addr_in[4];

	always_comb begin
		if (addr_in[13:8] == 6'h3F) begin
			// Palette repeats every 32 bytes
			addr_out = {6'h3F, 3'b000, pal_hi, addr_in[3:0]};
		end else if (addr_in[13]) begin
			// 0x3000-0x3EFF lands on the 0x2000 nametables
			addr_out = {2'b10, nt_out, addr_in[9:0]};
		end else begin
			// Pattern tables
			addr_out = addr_in;
		end
	end

endmodule

/* design/byte_ram.sv */
// Synchronous byte RAM
module byte_ram #(
	parameter int DEPTH = 256,
	parameter int AW = 8
) (
	input logic clk,
	input logic [AW-1:0] a_addr,
	input logic a_we,
	input nes_mem_pkg::byte_t a_wdata,
	output nes_mem_pkg::byte_t a_rdata,
	input logic [AW-1:0] b_addr,
	output nes_mem_pkg::byte_t b_rdata
);

	nes_mem_pkg::byte_t mem [DEPTH];

	// Read-write port, old contents come out on a write
	always_ff @(posedge clk) begin
		if (a_we) begin
			mem[a_addr] <= a_wdata;
		end
		a_rdata <= mem[a_addr];
	end

	// Read-only port
	always_ff @(posedge clk) begin
		b_rdata <= mem[b_addr];
	end

endmodule

/* design/ppu_reg_file.sv */
// Picture processor register block
module ppu_reg_file (
	input logic clk,
	input logic rst,
	input logic [2:0] reg_sel,
	input logic reg_we,
	input logic reg_re,
	input nes_mem_pkg::byte_t wdata,
	input nes_mem_pkg::byte_t ppu_status,
	output nes_mem_pkg::byte_t rdata,
	output logic busy,
	output nes_mem_pkg::byte_t ppu_ctrl,
	output nes_mem_pkg::byte_t ppu_mask,
	output logic [15:0] ppu_scroll,
	output nes_mem_pkg::byte_t oam_addr,
	output logic oam_we,
	output logic cpu_vreq,
	output logic cpu_vwe,
	output nes_mem_pkg::vram_addr_t cpu_vaddr,
	output nes_mem_pkg::byte_t cpu_vwdata,
	input logic cpu_vdone,
	input nes_mem_pkg::byte_t cpu_vrdata
);

	// Shared by scroll and address pairs
	logic toggle;
	nes_mem_pkg::byte_t buffer;
	nes_mem_pkg::vram_addr_t vaddr_step;

	assign vaddr_step = nes_mem_pkg::vram_addr_t'(ppu_ctrl[2] ? 32 : 1);
	assign oam_we = reg_we && (reg_sel == nes_mem_pkg::REG_OAM_DATA);
	assign busy = cpu_vreq;

	//////////////////////////////
	// Control state
	//////////////////////////////
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ppu_ctrl <= '0;
			ppu_mask <= '0;
			ppu_scroll <= '0;
			toggle <= 1'b0;
			oam_addr <= '0;
			cpu_vaddr <= '0;
			cpu_vreq <= 1'b0;
			cpu_vwe <= 1'b0;
			buffer <= '0;
		end else begin
			if (reg_we) begin
				case (reg_sel)
					nes_mem_pkg::REG_CTRL: ppu_ctrl <= wdata;
					nes_mem_pkg::REG_MASK: ppu_mask <= wdata;
					nes_mem_pkg::REG_OAM_ADDR: oam_addr <= wdata;
					nes_mem_pkg::REG_OAM_DATA: oam_addr <= oam_addr + 8'd1;
					nes_mem_pkg::REG_SCROLL: begin
						// X first, then Y
						if (!toggle) begin
							ppu_scroll[7:0] <= wdata;
						end else begin
							ppu_scroll[15:8] <= wdata;
						end
						toggle <= !toggle;
					end
					nes_mem_pkg::REG_ADDR: begin
						// High byte first
						if (!toggle) begin
							cpu_vaddr[13:8] <= wdata[5:0];
						end else begin
							cpu_vaddr[7:0] <= wdata;
						end
						toggle <= !toggle;
					end
					nes_mem_pkg::REG_DATA: begin
						cpu_vreq <= 1'b1;
						cpu_vwe <= 1'b1;
					end
					default: begin
					end
				endcase
			end
			if (reg_re) begin
				if (reg_sel == nes_mem_pkg::REG_STATUS) begin
					toggle <= 1'b0;
				end else if (reg_sel == nes_mem_pkg::REG_DATA) begin
					cpu_vreq <= 1'b1;
					cpu_vwe <= 1'b0;
				end
			end
			// Arbiter answered
			if (cpu_vdone) begin
				cpu_vreq <= 1'b0;
				if (!cpu_vwe) begin
					buffer <= cpu_vrdata;
				end
				cpu_vaddr <= cpu_vaddr + vaddr_step;
			end
		end
	end

	//////////////////////////////
	// Read data and write byte
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reg_we && reg_sel == nes_mem_pkg::REG_DATA) begin
			cpu_vwdata <= wdata;
		end
		if (reg_re) begin
			case (reg_sel)
				nes_mem_pkg::REG_CTRL: rdata <= ppu_ctrl;
				nes_mem_pkg::REG_MASK: rdata <= ppu_mask;
				nes_mem_pkg::REG_STATUS: rdata <= ppu_status;
				nes_mem_pkg::REG_OAM_ADDR: rdata <= oam_addr;
				nes_mem_pkg::REG_SCROLL: rdata <= ppu_scroll[7:0];
				nes_mem_pkg::REG_ADDR: rdata <= cpu_vaddr[7:0];
				// Stale byte, the fresh one lands in the buffer
				nes_mem_pkg::REG_DATA: rdata <= buffer;
				default: rdata <= '0;
			endcase
		end
	end

endmodule

/* design/vram_arbiter.sv */
// VRAM port arbiter
module vram_arbiter (
	input logic clk,
	input logic rst,
	input logic ppu_req,
	input nes_mem_pkg::vram_addr_t ppu_addr,
	output logic ppu_gnt,
	output nes_mem_pkg::byte_t ppu_rdata,
	input logic cpu_vreq,
	input logic cpu_vwe,
	input nes_mem_pkg::vram_addr_t cpu_vaddr,
	input nes_mem_pkg::byte_t cpu_vwdata,
	output logic cpu_vdone,
	output nes_mem_pkg::byte_t cpu_vrdata,
	output nes_mem_pkg::vram_addr_t mem_addr,
	output logic mem_we,
	output nes_mem_pkg::byte_t mem_wdata,
	input nes_mem_pkg::byte_t mem_rdata
);

	nes_mem_pkg::arb_state_e state;
	nes_mem_pkg::arb_state_e state_next;
	logic cpu_gnt;

	// Picture processor always wins
	assign ppu_gnt = ppu_req;

	// CPU request still held during its data cycle, so skip it there
	assign cpu_gnt = cpu_vreq && !ppu_req && (state != nes_mem_pkg::ARB_CPU);

	always_comb begin
		if (ppu_gnt) begin
			state_next = nes_mem_pkg::ARB_PPU;
		end else if (cpu_gnt) begin
			state_next = nes_mem_pkg::ARB_CPU;
		end else begin
			state_next = nes_mem_pkg::ARB_IDLE;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= nes_mem_pkg::ARB_IDLE;
		end else begin
			state <= state_next;
		end
	end

	//////////////////////////////
	// Memory port
	//////////////////////////////
	assign mem_addr = ppu_gnt ? ppu_addr : cpu_vaddr;
	assign mem_we = cpu_gnt && cpu_vwe;
	assign mem_wdata = cpu_vwdata;

	// Data of the previous grant
	assign ppu_rdata = mem_rdata;
	assign cpu_vrdata = mem_rdata;
	assign cpu_vdone = (state == nes_mem_pkg::ARB_CPU);

endmodule

/* design/mem_ctrl_top.sv */
// NES memory controller top
module mem_ctrl_top #(
	parameter int WRAM_BYTES = 2048,
	parameter int VRAM_BYTES = 16384
) (
	input logic clk,
	input logic rst,
	input nes_mem_pkg::cpu_addr_t cpu_addr,
	input nes_mem_pkg::byte_t cpu_wdata,
	input logic cpu_write_en,
	input logic cpu_read_en,
	output nes_mem_pkg::byte_t cpu_rdata,
	output logic cpu_ready,
	input logic ppu_req,
	input nes_mem_pkg::vram_addr_t ppu_addr,
	output logic ppu_gnt,
	output nes_mem_pkg::byte_t ppu_rdata,
	input nes_mem_pkg::byte_t oam_ppu_addr,
	output nes_mem_pkg::byte_t oam_ppu_data,
	input nes_mem_pkg::byte_t ppu_status,
	input nes_mem_pkg::byte_t joypad_1,
	input nes_mem_pkg::byte_t joypad_2,
	input nes_mem_pkg::mirror_e mirror_mode,
	output nes_mem_pkg::byte_t ppu_ctrl,
	output nes_mem_pkg::byte_t ppu_mask,
	output logic [15:0] ppu_scroll
);

	nes_mem_pkg::region_e region;
	nes_mem_pkg::region_e region_q;
	logic [10:0] wram_addr;
	logic [2:0] reg_sel;
	logic pad_sel;
	logic pad_q;
	logic oam_q;
	logic busy;
	logic wr_acc;
	logic rd_acc;
	logic rd_pending;
	nes_mem_pkg::byte_t wram_rdata;
	nes_mem_pkg::byte_t reg_rdata;
	nes_mem_pkg::byte_t oam_addr;
	nes_mem_pkg::byte_t oam_rdata;
	nes_mem_pkg::byte_t rd_mux;
	nes_mem_pkg::byte_t rd_hold;
	logic oam_we;
	logic cpu_vreq;
	logic cpu_vwe;
	logic cpu_vdone;
	nes_mem_pkg::vram_addr_t cpu_vaddr;
	nes_mem_pkg::byte_t cpu_vwdata;
	nes_mem_pkg::byte_t cpu_vrdata;
	nes_mem_pkg::vram_addr_t mem_addr;
	nes_mem_pkg::vram_addr_t mem_addr_mapped;
	logic mem_we;
	nes_mem_pkg::byte_t mem_wdata;
	nes_mem_pkg::byte_t mem_rdata;

	assign cpu_ready = !busy;
	assign wr_acc = cpu_write_en && cpu_ready;
	assign rd_acc = cpu_read_en && cpu_ready;

	cpu_addr_decode #(.WRAM_BYTES(WRAM_BYTES)) i_decode (
		.addr(cpu_addr), .region(region), .wram_addr(wram_addr),
		.reg_sel(reg_sel), .pad_sel(pad_sel)
	);

	byte_ram #(.DEPTH(WRAM_BYTES), .AW($clog2(WRAM_BYTES))) i_wram (
		.clk(clk), .a_addr(wram_addr), .a_we(wr_acc && region == nes_mem_pkg::REGION_WRAM),
		.a_wdata(cpu_wdata), .a_rdata(wram_rdata), .b_addr('0), .b_rdata()
	);

	ppu_reg_file i_regs (
		.clk(clk), .rst(rst), .reg_sel(reg_sel),
		.reg_we(wr_acc && region == nes_mem_pkg::REGION_REG),
		.reg_re(rd_acc && region == nes_mem_pkg::REGION_REG),
		.wdata(cpu_wdata), .ppu_status(ppu_status), .rdata(reg_rdata), .busy(busy),
		.ppu_ctrl(ppu_ctrl), .ppu_mask(ppu_mask), .ppu_scroll(ppu_scroll),
		.oam_addr(oam_addr), .oam_we(oam_we), .cpu_vreq(cpu_vreq), .cpu_vwe(cpu_vwe),
		.cpu_vaddr(cpu_vaddr), .cpu_vwdata(cpu_vwdata), .cpu_vdone(cpu_vdone),
		.cpu_vrdata(cpu_vrdata)
	);

	// Sprite table, port b feeds the picture processor
	byte_ram #(.DEPTH(256), .AW(8)) i_oam (
		.clk(clk), .a_addr(oam_addr), .a_we(oam_we), .a_wdata(cpu_wdata),
		.a_rdata(oam_rdata), .b_addr(oam_ppu_addr), .b_rdata(oam_ppu_data)
	);

	vram_arbiter i_arb (
		.clk(clk), .rst(rst), .ppu_req(ppu_req), .ppu_addr(ppu_addr), .ppu_gnt(ppu_gnt),
		.ppu_rdata(ppu_rdata), .cpu_vreq(cpu_vreq), .cpu_vwe(cpu_vwe),
		.cpu_vaddr(cpu_vaddr), .cpu_vwdata(cpu_vwdata), .cpu_vdone(cpu_vdone),
		.cpu_vrdata(cpu_vrdata), .mem_addr(mem_addr), .mem_we(mem_we),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
	);

	// Mapping after the arbiter so both requesters agree
	vram_addr_map i_map (
		.addr_in(mem_addr), .mirror_mode(mirror_mode), .addr_out(mem_addr_mapped)
	);

	byte_ram #(.DEPTH(VRAM_BYTES), .AW($clog2(VRAM_BYTES))) i_vram (
		.clk(clk), .a_addr(mem_addr_mapped), .a_we(mem_we), .a_wdata(mem_wdata),
		.a_rdata(mem_rdata), .b_addr('0), .b_rdata()
	);

	//////////////////////////////
	// CPU read return
	//////////////////////////////
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rd_pending <= 1'b0;
		end else begin
			rd_pending <= rd_acc;
		end
	end

	// Source of the read in flight
	always_ff @(posedge clk) begin
		if (rd_acc) begin
			region_q <= region;
			pad_q <= pad_sel;
			oam_q <= (reg_sel == nes_mem_pkg::REG_OAM_DATA);
		end
		if (rd_pending) begin
			rd_hold <= rd_mux;
		end
	end

	always_comb begin
		case (region_q)
			nes_mem_pkg::REGION_WRAM: rd_mux = wram_rdata;
			nes_mem_pkg::REGION_REG: rd_mux = oam_q ? oam_rdata : reg_rdata;
			nes_mem_pkg::REGION_PAD: rd_mux = pad_q ? joypad_2 : joypad_1;
			default: rd_mux = '0;
		endcase
	end

	// Held until the next read comes back
	assign cpu_rdata = rd_pending ? rd_mux : rd_hold;

endmodule

/* verification/mem_checker.sv */
// Read data checker
module mem_checker (
	input logic clk,
	input logic rst,
	input logic cpu_read_en,
	input logic cpu_write_en,
	input logic cpu_ready,
	input logic [7:0] cpu_rdata,
	input logic cpu_chk,
	input logic [7:0] cpu_exp,
	input logic ppu_gnt,
	input logic [7:0] ppu_rdata,
	input logic ppu_chk,
	input logic [7:0] ppu_exp,
	input logic [7:0] oam_ppu_data,
	input logic oam_chk,
	input logic [7:0] oam_exp,
	input logic [7:0] ppu_ctrl,
	input logic [7:0] ppu_mask,
	input logic [15:0] ppu_scroll,
	input logic [7:0] ctrl_exp,
	input logic [7:0] mask_exp,
	input logic [15:0] scroll_exp,
	output int errors,
	output int checks
);
	timeunit 1ns;
	timeprecision 100ps;

	logic cpu_due;
	logic ppu_due;
	logic oam_due;
	logic regs_due;
	logic [7:0] cpu_want;
	logic [7:0] ppu_want;
	logic [7:0] oam_want;

	task automatic compare(input string name, input logic [7:0] want, input logic [7:0] got);
		checks = checks + 1;
		if (got !== want) begin
			errors = errors + 1;
			$display("ERROR at %0.1f ns: %s expected %02h actual %02h",
				$realtime, name, want, got);
		end
	endtask

	// Sampled mid-cycle, away from both edges
	always @(negedge clk) begin
		if (!rst) begin
			cpu_due <= 1'b0;
			ppu_due <= 1'b0;
			oam_due <= 1'b0;
			regs_due <= 1'b0;
			errors = 0;
			checks = 0;
		end else begin
			// Data of last cycle's accesses
			if (cpu_due) begin
				compare("cpu_rdata", cpu_want, cpu_rdata);
			end
			if (ppu_due) begin
				compare("ppu_rdata", ppu_want, ppu_rdata);
			end
			if (oam_due) begin
				compare("oam_ppu_data", oam_want, oam_ppu_data);
			end
			// Register outputs after a CPU write
			if (regs_due) begin
				compare("ppu_ctrl", ctrl_exp, ppu_ctrl);
				compare("ppu_mask", mask_exp, ppu_mask);
				compare("ppu_scroll[7:0]", scroll_exp[7:0], ppu_scroll[7:0]);
				compare("ppu_scroll[15:8]", scroll_exp[15:8], ppu_scroll[15:8]);
			end
			// Accesses taken at the coming edge
			cpu_due <= cpu_read_en && cpu_ready && cpu_chk;
			cpu_want <= cpu_exp;
			ppu_due <= ppu_gnt && ppu_chk;
			ppu_want <= ppu_exp;
			oam_due <= oam_chk;
			oam_want <= oam_exp;
			regs_due <= cpu_write_en && cpu_ready;
		end
	end

endmodule

/* verification/tb_mem_ctrl.sv */
// Memory controller testbench
module tb_mem_ctrl;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 100;

	logic clk;
	logic rst;
	nes_mem_pkg::cpu_addr_t cpu_addr;
	nes_mem_pkg::byte_t cpu_wdata;
	logic cpu_write_en;
	logic cpu_read_en;
	nes_mem_pkg::byte_t cpu_rdata;
	logic cpu_ready;
	logic ppu_req;
	nes_mem_pkg::vram_addr_t ppu_addr;
	logic ppu_gnt;
	nes_mem_pkg::byte_t ppu_rdata;
	nes_mem_pkg::byte_t oam_ppu_addr;
	nes_mem_pkg::byte_t oam_ppu_data;
	nes_mem_pkg::byte_t ppu_status;
	nes_mem_pkg::byte_t joypad_1;
	nes_mem_pkg::byte_t joypad_2;
	nes_mem_pkg::mirror_e mirror_mode;
	nes_mem_pkg::byte_t ppu_ctrl;
	nes_mem_pkg::byte_t ppu_mask;
	logic [15:0] ppu_scroll;
	logic cpu_chk;
	logic ppu_chk;
	logic oam_chk;
	logic [7:0] cpu_exp;
	logic [7:0] ppu_exp;
	logic [7:0] oam_exp;
	logic [7:0] ctrl_exp;
	logic [7:0] mask_exp;
	logic [15:0] scroll_exp;
	logic toggle_exp;
	logic aborted;
	int errors;
	int checks;

	mem_ctrl_top i_dut (.*);

	mem_checker i_chk (
		.clk(clk), .rst(rst), .cpu_read_en(cpu_read_en), .cpu_write_en(cpu_write_en),
		.cpu_ready(cpu_ready), .cpu_rdata(cpu_rdata), .cpu_chk(cpu_chk), .cpu_exp(cpu_exp),
		.ppu_gnt(ppu_gnt), .ppu_rdata(ppu_rdata), .ppu_chk(ppu_chk), .ppu_exp(ppu_exp),
		.oam_ppu_data(oam_ppu_data), .oam_chk(oam_chk), .oam_exp(oam_exp),
		.ppu_ctrl(ppu_ctrl), .ppu_mask(ppu_mask), .ppu_scroll(ppu_scroll),
		.ctrl_exp(ctrl_exp), .mask_exp(mask_exp), .scroll_exp(scroll_exp),
		.errors(errors), .checks(checks)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic idle_cycles(input int count);
		repeat (count) begin
			@(posedge clk);
			#0.5;
		end
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!cpu_ready && !aborted) begin
			@(posedge clk);
			#0.5;
			n++;
			if (n >= TIMEOUT) begin
				$display("Timeout: cpu_ready stayed low for %0d cycles", TIMEOUT);
				aborted = 1'b1;
			end
		end
	endtask

	// Expected ctrl, mask and scroll after one CPU access
	task automatic update_reg_model(input logic we, input logic [15:0] addr,
			input logic [7:0] data);
		if (addr[15:13] == 3'b001 && we) begin
			case (addr[2:0])
				nes_mem_pkg::REG_CTRL: ctrl_exp = data;
				nes_mem_pkg::REG_MASK: mask_exp = data;
				nes_mem_pkg::REG_SCROLL: begin
					if (toggle_exp) begin
						scroll_exp[15:8] = data;
					end else begin
						scroll_exp[7:0] = data;
					end
					toggle_exp = !toggle_exp;
				end
				nes_mem_pkg::REG_ADDR: toggle_exp = !toggle_exp;
				default: begin
				end
			endcase
		end else if (addr[15:13] == 3'b001 && addr[2:0] == nes_mem_pkg::REG_STATUS) begin
			// Status read restarts both pairs
			toggle_exp = 1'b0;
		end
	endtask

	// One strobe, held for exactly one cycle
	task automatic cpu_access(input logic we, input logic [15:0] addr, input logic [7:0] data,
			input logic [7:0] exp, input logic exp_on);
		wait_ready();
		cpu_addr = addr;
		cpu_wdata = data;
		cpu_write_en = we;
		cpu_read_en = !we;
		cpu_exp = exp;
		cpu_chk = exp_on && !we;
		@(posedge clk);
		#0.5;
		cpu_write_en = 1'b0;
		cpu_read_en = 1'b0;
		cpu_chk = 1'b0;
		update_reg_model(we, addr, data);
	endtask

	task automatic ppu_read(input logic [13:0] addr, input logic [7:0] exp, input logic exp_on);
		int n;
		n = 0;
		ppu_req = 1'b1;
		ppu_addr = addr;
		ppu_exp = exp;
		ppu_chk = exp_on;
		do begin
			@(posedge clk);
			n++;
		end while (!ppu_gnt && n < TIMEOUT);
		if (!ppu_gnt) begin
			$display("Timeout: ppu_gnt never came for address %04h", addr);
			aborted = 1'b1;
		end
		#0.5;
		ppu_req = 1'b0;
		ppu_chk = 1'b0;
	endtask

	task automatic oam_read(input logic [7:0] addr, input logic [7:0] exp, input logic exp_on);
		oam_ppu_addr = addr;
		oam_exp = exp;
		oam_chk = exp_on;
		@(posedge clk);
		#0.5;
		oam_chk = 1'b0;
	endtask

	//////////////////////////////
	// Pattern file driver
	//////////////////////////////
	initial begin
		int fd;
		int n;
		int rnd;
		logic [63:0] port_s;
		logic [63:0] op_s;
		logic [63:0] data_s;
		logic [63:0] exp_s;
		logic [15:0] addr_v;
		logic [7:0] data_v;
		logic [7:0] exp_v;
		logic exp_on;
		logic [1023:0] rest;
		rnd = $urandom(2);
		rst = 1'b0;
		aborted = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_write_en = 1'b0;
		cpu_read_en = 1'b0;
		ppu_req = 1'b0;
		ppu_addr = '0;
		oam_ppu_addr = '0;
		ppu_status = 8'hC3;
		joypad_1 = 8'h5A;
		joypad_2 = 8'h81;
		mirror_mode = nes_mem_pkg::MIRROR_VERTICAL;
		cpu_chk = 1'b0;
		ppu_chk = 1'b0;
		oam_chk = 1'b0;
		cpu_exp = '0;
		ppu_exp = '0;
		oam_exp = '0;
		ctrl_exp = '0;
		mask_exp = '0;
		scroll_exp = '0;
		toggle_exp = 1'b0;
		repeat (8) @(posedge clk);
		#0.5;
		rst = 1'b1;
		fd = $fopen("verification/mem_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open verification/mem_patterns.txt");
			aborted = 1'b1;
		end
		while (!aborted) begin
			n = $fscanf(fd, "%s", port_s);
			if (n != 1) begin
				break;
			end
			if (port_s == 64'("#")) begin
				n = $fgets(rest, fd);
			end else begin
				n = $fscanf(fd, "%s %h %s %s", op_s, addr_v, data_s, exp_s);
				data_v = 8'h00;
				exp_v = 8'h00;
				exp_on = (exp_s != 64'("-"));
				if (data_s != 64'("-")) begin
					n = $sscanf(data_s, "%h", data_v);
				end
				if (exp_on) begin
					n = $sscanf(exp_s, "%h", exp_v);
				end
				// A cut-in request must land while the CPU access is pending
				if (op_s != 64'("rdx")) begin
					idle_cycles(int'($urandom % 4));
				end
				if (port_s == 64'("cpu") && op_s == 64'("wr")) begin
					cpu_access(1'b1, addr_v, data_v, exp_v, 1'b0);
				end else if (port_s == 64'("cpu") && op_s == 64'("rd")) begin
					cpu_access(1'b0, addr_v, data_v, exp_v, exp_on);
				end else if (port_s == 64'("ppu") && op_s == 64'("rd")) begin
					wait_ready();
					ppu_read(addr_v[13:0], exp_v, exp_on);
				end else if (port_s == 64'("ppu") && op_s == 64'("rdx")) begin
					ppu_read(addr_v[13:0], exp_v, exp_on);
				end else if (port_s == 64'("ppu") && op_s == 64'("oam")) begin
					oam_read(addr_v[7:0], exp_v, exp_on);
				end else if (port_s == 64'("ppu") && op_s == 64'("mir")) begin
					mirror_mode = data_v[0] ? nes_mem_pkg::MIRROR_VERTICAL
						: nes_mem_pkg::MIRROR_HORIZONTAL;
				end else begin
					$display("Unknown operation in the pattern file");
					aborted = 1'b1;
				end
			end
		end
		wait_ready();
		idle_cycles(3);
		if (fd != 0) begin
			$fclose(fd);
		end
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0 && checks > 0 && !aborted) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* verification/mem_patterns.txt */
# Columns are port, operation, address, data and expected value, all in hex
# A dash marks an unused column and rdx cuts in while a CPU access is pending
cpu wr 0123 3c -
cpu rd 0923 - 3c
cpu rd 1923 - 3c
cpu rd 5000 - 00
cpu wr 2000 11 -
cpu rd 2008 - 11
cpu rd 2002 - c3
cpu rd 4016 - 5a
cpu rd 4017 - 81
# Address pair restarted by a status read
cpu wr 2006 3f -
cpu rd 2002 - c3
cpu wr 2006 20 -
cpu wr 2006 00 -
cpu wr 2007 a1 -
cpu wr 2007 b2 -
cpu wr 2006 20 -
cpu wr 2006 00 -
cpu rd 2007 - 00
cpu rd 2007 - a1
# Vertical mirroring
ppu rd 2800 - a1
ppu rd 3001 - b2
ppu mir 0000 0 -
ppu rd 2401 - b2
# Palette fold
cpu wr 2006 3f -
cpu wr 2006 10 -
cpu wr 2007 5e -
ppu rd 3f00 - 5e
ppu rd 3f20 - 5e
# Step of 32
cpu wr 2000 04 -
cpu wr 2006 21 -
cpu wr 2006 00 -
cpu wr 2007 c4 -
cpu wr 2007 d5 -
ppu rd 2120 - d5
ppu rd 2500 - c4
# Picture processor traffic during a pending CPU read
cpu wr 2000 00 -
cpu wr 2006 21 -
cpu wr 2006 20 -
cpu rd 2007 - b2
ppu rdx 2000 - a1
ppu rdx 2100 - c4
ppu rdx 3f00 - 5e
cpu rd 2007 - d5
# Sprite table
cpu wr 2003 10 -
cpu wr 2004 7a -
cpu wr 2004 7b -
cpu wr 2004 7c -
cpu rd 2003 - 13
ppu oam 0010 - 7a
ppu oam 0011 - 7b
ppu oam 0012 - 7c

/* compile.f */
design/nes_mem_pkg.sv
design/cpu_addr_decode.sv
design/vram_addr_map.sv
design/byte_ram.sv
design/ppu_reg_file.sv
design/vram_arbiter.sv
design/mem_ctrl_top.sv
verification/mem_checker.sv
verification/tb_mem_ctrl.sv

/* Makefile */
SIM := obj_dir/Vtb_mem_ctrl

.PHONY: all run clean

all: run

$(SIM): compile.f $(wildcard design/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --top-module tb_mem_ctrl -f compile.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
